// File: tb.f
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_reg.sv
hdl/reg_file.sv
hdl/decoder.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/pipelined.sv
dv/tb_clock.sv
dv/pipelined_assert.sv
dv/tb_pipelined.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pipelined -f tb.f \
    -o sim_pipelined > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_pipelined > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

// File: dv/tb_pipelined.sv
`timescale 1ns/1ps

module tb_pipelined import rv_isa_pkg::*, pipe_pkg::*;;

    localparam int PROG_LEN = 64;
    localparam int TIMEOUT  = 6 * PROG_LEN + 40;

    logic              CLK;
    logic              RESET_N;
    logic [DATA_W-1:0] idata, ddata_r, ddata_w, reg_write_data;
    logic [ADDR_W-1:0] iaddr, daddr;
    logic              mem_write, mem_read, reg_write_enable;
    logic [4:0]        write_register;

    // memories seen by the DUT and by the model
    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:1023];
    logic [31:0] gold_mem [0:1023];
    logic [31:0] prog [0:PROG_LEN-1];

    // expected events in program order
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    int          exp_kind [$];
    logic [9:0]  st_addr [$];
    logic [31:0] st_data [$];
    int          st_kind [$];
    logic [9:0]  ld_addr [$];
    int          ld_kind [$];

    int    chk [1:5];
    int    err [1:5];
    string beh_name [1:5];
    int    edges;
    logic  timed_out;

    tb_clock u_clock (.CLK(CLK), .RESET_N(RESET_N));

    pipelined UUT (
        .CLK(CLK), .RESET_N(RESET_N), .idata(idata), .iaddr(iaddr), .daddr(daddr),
        .ddata_r(ddata_r), .ddata_w(ddata_w), .mem_write(mem_write), .mem_read(mem_read),
        .reg_write_data(reg_write_data), .reg_write_enable(reg_write_enable),
        .write_register(write_register)
    );

    bind pipelined pipelined_assert u_pipelined_assert (
        .CLK(CLK), .RESET_N(RESET_N), .mem_read(mem_read), .mem_write(mem_write),
        .reg_write_enable(reg_write_enable), .write_register(write_register), .flush(flush)
    );

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (mem_write) dmem[daddr] <= ddata_w;
    end

    // cycles since reset release
    always @(posedge CLK) begin
        if (RESET_N) edges <= edges + 1;
    end

    function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        logic [12:0] imm;
        imm = 13'(off);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // reference arithmetic per the instruction set
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input int i);
        int          kind;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        kind = $urandom_range(0, 9);
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom);
        // branches need room for a forward target
        if (kind >= 8 && i > PROG_LEN - 5) kind = 0;
        case (kind)
            0, 1: return {((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ?
                          7'b0100000 : 7'b0, rs2, rs1, f3, rd, OPC_OP};
            2, 3: begin
                // shift immediates carry the shamt only
                if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            4: return {20'($urandom), rd, OPC_LUI};
            5: return {20'($urandom), rd, OPC_AUIPC};
            6: return {4'b0, 6'($urandom_range(0, 63)), 2'b0, 5'd0, FUNCT3_LW, rd, OPC_LOAD};
            7: begin
                imm = {4'b0, 6'($urandom_range(0, 63)), 2'b0};
                return {imm[11:5], rs2, 5'd0, FUNCT3_SW, imm[4:0], OPC_STORE};
            end
            default: return enc_b(4 * $urandom_range(2, 4), rs2, rs1,
                                  ($urandom_range(0, 1) == 1) ? FUNCT3_BNE : FUNCT3_BEQ);
        endcase
    endfunction

    // golden model runs the program in order up to the final self-loop
    task automatic run_model();
        logic [31:0] rf [0:31];
        logic [31:0] ins, a, b, val, imm_i, imm_b, eff;
        logic [4:0]  rd, rs1, rs2;
        logic [4:0]  prev_rd;
        logic        wr, dep, after_branch;
        int          pc_idx, next, kind;
        for (int r = 0; r < 32; r++) rf[r] = '0;
        pc_idx       = 0;
        prev_rd      = 5'd0;
        after_branch = 1'b0;
        while (pc_idx < PROG_LEN - 1) begin
            ins   = prog[pc_idx];
            rd    = ins[11:7];
            rs1   = ins[19:15];
            rs2   = ins[24:20];
            a     = rf[rs1];
            b     = rf[rs2];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            next  = pc_idx + 1;
            wr    = 1'b1;
            val   = '0;
            // read of a register the previous instruction just wrote
            dep = prev_rd != 5'd0 && ins[6:0] != OPC_LUI && ins[6:0] != OPC_AUIPC &&
                  (rs1 == prev_rd || (rs2 == prev_rd &&
                   (ins[6:0] == OPC_OP || ins[6:0] == OPC_STORE || ins[6:0] == OPC_BRANCH)));
            kind = after_branch ? 4 : (dep ? 3 : 1);
            case (ins[6:0])
                OPC_OP:     val = ref_alu(ins[14:12], ins[30], a, b);
                OPC_OP_IMM: val = ref_alu(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
                OPC_LUI:    val = {ins[31:12], 12'b0};
                OPC_AUIPC:  val = 32'(pc_idx * 4) + {ins[31:12], 12'b0};
                OPC_LOAD: begin
                    eff  = a + imm_i;
                    val  = gold_mem[eff[11:2]];
                    kind = after_branch ? 4 : 2;
                    ld_addr.push_back(eff[11:2]);
                    ld_kind.push_back(kind);
                end
                OPC_STORE: begin
                    wr  = 1'b0;
                    eff = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    gold_mem[eff[11:2]] = b;
                    st_addr.push_back(eff[11:2]);
                    st_data.push_back(b);
                    st_kind.push_back(after_branch ? 4 : (dep ? 3 : 2));
                end
                default: begin
                    wr = 1'b0;
                    if ((ins[14:12] == FUNCT3_BNE) ? (a != b) : (a == b))
                        next = pc_idx + int'($signed(imm_b)) / 4;
                end
            endcase
            if (wr && rd != 5'd0) begin
                rf[rd] = val;
                exp_rd.push_back(rd);
                exp_val.push_back(val);
                exp_kind.push_back(kind);
            end
            prev_rd      = (wr) ? rd : 5'd0;
            after_branch = ins[6:0] == OPC_BRANCH;
            pc_idx       = next;
        end
    endtask

    task automatic check_eq(input int beh, input string what, input logic [31:0] exp, act);
        chk[beh]++;
        assert (exp === act) else begin
            err[beh]++;
            $display("[FAIL] %s %s expected %h actual %h", beh_name[beh], what, exp, act);
        end
    endtask

    // events are sampled half a cycle after the edge that produced them
    always @(negedge CLK) begin
        if (RESET_N && (reg_write_enable || mem_write)) begin
            chk[5]++;
            // first store reaches memory on edge 3 and first writeback comes on edge 4
            assert (edges >= (reg_write_enable ? 4 : 3)) else begin
                err[5]++;
                $display("write strobe at cycle %0d, before any instruction could get there",
                         edges);
            end
        end
        if (RESET_N && reg_write_enable) begin
            chk[4]++;
            assert (exp_rd.size() != 0) else begin
                err[4]++;
                $display("register write to x%0d that the model does not expect",
                         write_register);
            end
            if (exp_rd.size() != 0) begin
                check_eq(exp_kind[0], "rd", 32'(exp_rd[0]), 32'(write_register));
                check_eq(exp_kind[0], "data", exp_val[0], reg_write_data);
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
                void'(exp_kind.pop_front());
            end
        end
        if (RESET_N && mem_read) begin
            chk[4]++;
            assert (ld_addr.size() != 0) else begin
                err[4]++;
                $display("load from word %0d that the model does not expect", daddr);
            end
            if (ld_addr.size() != 0) begin
                check_eq(ld_kind[0], "load address", 32'(ld_addr[0]), 32'(daddr));
                void'(ld_addr.pop_front());
                void'(ld_kind.pop_front());
            end
        end
        if (RESET_N && mem_write) begin
            chk[4]++;
            assert (st_addr.size() != 0) else begin
                err[4]++;
                $display("store to word %0d that the model does not expect", daddr);
            end
            if (st_addr.size() != 0) begin
                check_eq(st_kind[0], "store address", 32'(st_addr[0]), 32'(daddr));
                check_eq(st_kind[0], "store data", st_data[0], ddata_w);
                void'(st_addr.pop_front());
                void'(st_data.pop_front());
                void'(st_kind.pop_front());
            end
        end
    end

    initial begin
        int total_chk;
        int total_err;
        void'($urandom(81619));
        edges     = 0;
        timed_out = 1'b0;
        beh_name[1] = "alu_lui_auipc_retire";
        beh_name[2] = "load_store";
        beh_name[3] = "dependent_operand";
        beh_name[4] = "branch_flush";
        beh_name[5] = "reset_and_completion";
        for (int k = 1; k <= 5; k++) begin
            chk[k] = 0;
            err[k] = 0;
        end
        // fill depends on every address bit
        for (int w = 0; w < 1024; w++) begin
            imem[w]     = '0;
            dmem[w]     = (32'(w) * 32'h9E3779B1) ^ 32'hC3A5_0F1E;
            gold_mem[w] = dmem[w];
        end
        for (int i = 0; i < PROG_LEN - 1; i++) prog[i] = make_instr(i);
        // beq x0, x0, 0 parks the core
        prog[PROG_LEN-1] = enc_b(0, 5'd0, 5'd0, FUNCT3_BEQ);
        for (int i = 0; i < PROG_LEN; i++) imem[i] = prog[i];
        run_model();

        wait (RESET_N);
        while ((exp_rd.size() != 0 || st_addr.size() != 0 || ld_addr.size() != 0) &&
               edges < TIMEOUT)
            @(posedge CLK);
        timed_out = exp_rd.size() != 0 || st_addr.size() != 0 || ld_addr.size() != 0;
        // tail catches writes from instructions that should have been flushed
        repeat (12) @(posedge CLK);
        chk[5]++;
        assert (!timed_out) else begin
            err[5]++;
            $display("timeout after %0d cycles with %0d writes, %0d loads, %0d stores missing",
                     edges, exp_rd.size(), ld_addr.size(), st_addr.size());
        end

        total_chk = 0;
        total_err = 0;
        for (int k = 1; k <= 5; k++) begin
            $display("%s: %0d checks, %0d errors", beh_name[k], chk[k], err[k]);
            total_chk += chk[k];
            total_err += err[k];
        end
        $display("total: %0d checks, %0d errors", total_chk, total_err);
        if (total_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: dv/pipelined_assert.sv
`timescale 1ns/1ps

module pipelined_assert (
    input logic       CLK,
    input logic       RESET_N,
    input logic       mem_read,
    input logic       mem_write,
    input logic       reg_write_enable,
    input logic [4:0] write_register,
    input logic       flush
);

    // one memory stage, so one kind of access at a time
    rd_wr_exclusive: assert property (
        @(posedge CLK) disable iff (!RESET_N) !(mem_read && mem_write)
    ) else $error("data port read and write strobes are high together");

    // x0 writes are filtered before the port
    no_x0_write: assert property (
        @(posedge CLK) disable iff (!RESET_N) reg_write_enable |-> write_register != 5'd0
    ) else $error("register write strobe raised for x0");

    // the flushed memory stage cannot hold a second branch
    flush_one_cycle: assert property (
        @(posedge CLK) disable iff (!RESET_N) flush |=> !flush
    ) else $error("flush stayed high for more than one cycle");

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic RESET_N
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // reset held for four cycles, released just after an edge
    initial begin
        RESET_N = 1'b0;
        repeat (4) @(posedge CLK);
        #1 RESET_N = 1'b1;
    end

endmodule

// File: hdl/pipelined.sv
`timescale 1ns/1ps

module pipelined import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic              CLK,
    input  logic              RESET_N,
    input  logic [DATA_W-1:0] idata,
    output logic [ADDR_W-1:0] iaddr,
    output logic [ADDR_W-1:0] daddr,
    input  logic [DATA_W-1:0] ddata_r,
    output logic [DATA_W-1:0] ddata_w,
    output logic              mem_write,
    output logic              mem_read,
    output logic [DATA_W-1:0] reg_write_data,
    output logic              reg_write_enable,
    output logic [4:0]        write_register
);

    logic [PC_W-1:0]   pc;
    logic [PC_W-1:0]   pc_plus4;
    logic              stall;
    logic              flush;
    logic              branch_taken;
    if_id_t            if_id_d, if_id_q;
    id_ex_t            id_ex_d, id_ex_q;
    ex_mem_t           ex_mem_d, ex_mem_q;
    mem_wb_t           mem_wb_d, mem_wb_q;
    logic [DATA_W-1:0] dec_imm;
    alu_op_e           dec_alu_op;
    logic              dec_alu_src_imm, dec_reg_write, dec_mem_read, dec_mem_write;
    logic              dec_branch, dec_uses_rs1, dec_uses_rs2;
    wb_src_e           dec_wb_src;
    logic [DATA_W-1:0] rdata1, rdata2;
    logic [DATA_W-1:0] alu_b, alu_result;
    logic              alu_zero;

    // fetch
    assign pc_plus4 = pc + PC_W'(4);
    assign iaddr    = pc[PC_W-1:2];

    // branch target wins, stall freezes
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (flush) begin
            pc <= ex_mem_q.target[PC_W-1:0];
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    assign if_id_d = '{valid: 1'b1, pc: pc, instr: idata};

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .CLK(CLK), .RESET_N(RESET_N), .hold(stall), .bubble(flush), .d(if_id_d), .q(if_id_q)
    );

    // decode
    decoder u_decoder (
        .instr(if_id_q.instr), .imm(dec_imm), .alu_op(dec_alu_op),
        .alu_src_imm(dec_alu_src_imm), .reg_write(dec_reg_write),
        .mem_read(dec_mem_read), .mem_write(dec_mem_write), .branch(dec_branch),
        .wb_src(dec_wb_src), .uses_rs1(dec_uses_rs1), .uses_rs2(dec_uses_rs2)
    );

    reg_file u_reg_file (
        .CLK(CLK), .RESET_N(RESET_N),
        .rs1(if_id_q.instr[19:15]), .rs2(if_id_q.instr[24:20]),
        .rd(write_register), .wdata(reg_write_data), .we(reg_write_enable),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    // pending destinations only count for live stages
    hazard_unit u_hazard (
        .rs1(if_id_q.instr[19:15]), .rs2(if_id_q.instr[24:20]),
        .uses_rs1(if_id_q.valid && dec_uses_rs1), .uses_rs2(if_id_q.valid && dec_uses_rs2),
        .ex_rd(id_ex_q.rd), .ex_reg_write(id_ex_q.valid && id_ex_q.reg_write),
        .mem_rd(ex_mem_q.rd), .mem_reg_write(ex_mem_q.valid && ex_mem_q.reg_write),
        .branch_taken(branch_taken), .stall(stall), .flush(flush)
    );

    always_comb begin
        id_ex_d.valid       = if_id_q.valid;
        id_ex_d.reg_write   = dec_reg_write;
        id_ex_d.mem_read    = dec_mem_read;
        id_ex_d.mem_write   = dec_mem_write;
        id_ex_d.branch      = dec_branch;
        id_ex_d.alu_src_imm = dec_alu_src_imm;
        id_ex_d.wb_src      = dec_wb_src;
        id_ex_d.pc          = if_id_q.pc;
        // unused rs1 reads as x0, which is how LUI gets 0 + imm
        id_ex_d.op1         = dec_uses_rs1 ? rdata1 : '0;
        id_ex_d.op2         = rdata2;
        id_ex_d.imm         = dec_imm;
        id_ex_d.alu_op      = dec_alu_op;
        id_ex_d.rd          = if_id_q.instr[11:7];
        id_ex_d.funct3      = if_id_q.instr[14:12];
    end

    // stall inserts a bubble behind the held decode
    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .CLK(CLK), .RESET_N(RESET_N), .hold(1'b0), .bubble(stall || flush),
        .d(id_ex_d), .q(id_ex_q)
    );

    // execute
    assign alu_b = id_ex_q.alu_src_imm ? id_ex_q.imm : id_ex_q.op2;

    alu u_alu (
        .a(id_ex_q.op1), .b(alu_b), .op(id_ex_q.alu_op), .result(alu_result), .zero(alu_zero)
    );

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.reg_write  = id_ex_q.reg_write;
        ex_mem_d.mem_read   = id_ex_q.mem_read;
        ex_mem_d.mem_write  = id_ex_q.mem_write;
        ex_mem_d.branch     = id_ex_q.branch;
        ex_mem_d.wb_src     = id_ex_q.wb_src;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.zero       = alu_zero;
        ex_mem_d.store_data = id_ex_q.op2;
        // branch target and auipc share one adder
        ex_mem_d.target     = {{(DATA_W-PC_W){1'b0}}, id_ex_q.pc} + id_ex_q.imm;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.funct3     = id_ex_q.funct3;
    end

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .CLK(CLK), .RESET_N(RESET_N), .hold(1'b0), .bubble(flush), .d(ex_mem_d), .q(ex_mem_q)
    );

    // memory
    // beq takes on zero, bne on nonzero
    assign branch_taken = ex_mem_q.valid && ex_mem_q.branch &&
                          (ex_mem_q.zero != (ex_mem_q.funct3 == FUNCT3_BNE));

    assign daddr     = ex_mem_q.alu_result[ADDR_W+1:2];
    assign ddata_w   = ex_mem_q.store_data;
    assign mem_write = ex_mem_q.valid && ex_mem_q.mem_write;
    assign mem_read  = ex_mem_q.valid && ex_mem_q.mem_read;

    assign mem_wb_d = '{
        valid:      ex_mem_q.valid,
        reg_write:  ex_mem_q.reg_write,
        wb_src:     ex_mem_q.wb_src,
        alu_result: ex_mem_q.alu_result,
        load_data:  ddata_r,
        rd:         ex_mem_q.rd,
        link:       ex_mem_q.target
    };

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .CLK(CLK), .RESET_N(RESET_N), .hold(1'b0), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    // writeback
    always_comb begin
        case (mem_wb_q.wb_src)
            WB_MEM:    reg_write_data = mem_wb_q.load_data;
            WB_PC_IMM: reg_write_data = mem_wb_q.link;
            default:   reg_write_data = mem_wb_q.alu_result;
        endcase
    end

    // x0 writes never show up on the port
    assign reg_write_enable = mem_wb_q.valid && mem_wb_q.reg_write && mem_wb_q.rd != 5'd0;
    assign write_register   = mem_wb_q.rd;

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic       uses_rs1,
    input  logic       uses_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_reg_write,
    input  logic [4:0] mem_rd,
    input  logic       mem_reg_write,
    input  logic       branch_taken,
    output logic       stall,
    output logic       flush
);

    logic rs1_pending;
    logic rs2_pending;

    // x0 never creates a dependency
    // writeback is covered by the register file pass-through
    assign rs1_pending = uses_rs1 && rs1 != 5'd0 &&
                         ((ex_reg_write && ex_rd == rs1) ||
                          (mem_reg_write && mem_rd == rs1));

    assign rs2_pending = uses_rs2 && rs2 != 5'd0 &&
                         ((ex_reg_write && ex_rd == rs2) ||
                          (mem_reg_write && mem_rd == rs2));

    // taken branch squashes the younger three
    assign flush = branch_taken;

    // stalled instruction is flushed anyway when a branch goes
    assign stall = (rs1_pending || rs2_pending) && !branch_taken;

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  alu_op_e           op,
    output logic [DATA_W-1:0] result,
    output logic              zero
);

    logic [4:0] shamt;

    // shifts take only the low five bits
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            // signed compare
            ALU_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(DATA_W-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic right shift keeps the sign
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // used by branches after a subtract
    assign zero = (result == '0);

endmodule

// File: hdl/decoder.sv
`timescale 1ns/1ps

module decoder import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic [DATA_W-1:0] instr,
    output logic [DATA_W-1:0] imm,
    output alu_op_e           alu_op,
    output logic              alu_src_imm,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch,
    output wb_src_e           wb_src,
    output logic              uses_rs1,
    output logic              uses_rs2
);

    logic [2:0]        funct3;
    logic [DATA_W-1:0] imm_i;
    logic [DATA_W-1:0] imm_s;
    logic [DATA_W-1:0] imm_b;
    logic [DATA_W-1:0] imm_u;
    alu_op_e           arith_op;

    assign funct3 = instr[14:12];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // arithmetic select for OP and OP_IMM
    always_comb begin
        case (funct3)
            // no SUBI, so bit 30 only counts for register form
            FUNCT3_ADD_SUB: arith_op = (instr[6:0] == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:     arith_op = ALU_SLL;
            FUNCT3_SLT:     arith_op = ALU_SLT;
            FUNCT3_SLTU:    arith_op = ALU_SLTU;
            FUNCT3_XOR:     arith_op = ALU_XOR;
            FUNCT3_SRL_SRA: arith_op = instr[30] ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:      arith_op = ALU_OR;
            default:        arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // defaults give a nop with no writes
        imm         = imm_i;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        wb_src      = WB_ALU;
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        case (instr[6:0])
            OPC_OP: begin
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                alu_op    = arith_op;
            end
            OPC_OP_IMM: begin
                reg_write   = 1'b1;
                uses_rs1    = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = arith_op;
            end
            OPC_LOAD: begin
                // word loads only
                if (funct3 == FUNCT3_LW) begin
                    reg_write   = 1'b1;
                    mem_read    = 1'b1;
                    uses_rs1    = 1'b1;
                    alu_src_imm = 1'b1;
                    wb_src      = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (funct3 == FUNCT3_SW) begin
                    mem_write   = 1'b1;
                    uses_rs1    = 1'b1;
                    uses_rs2    = 1'b1;
                    alu_src_imm = 1'b1;
                    imm         = imm_s;
                end
            end
            OPC_BRANCH: begin
                // compare by subtraction, zero flag decides
                if (funct3 == FUNCT3_BEQ || funct3 == FUNCT3_BNE) begin
                    branch   = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                    alu_op   = ALU_SUB;
                    imm      = imm_b;
                end
            end
            OPC_LUI: begin
                // first operand stays zero since rs1 is unused
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_u;
            end
            OPC_AUIPC: begin
                reg_write = 1'b1;
                imm       = imm_u;
                wb_src    = WB_PC_IMM;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import pipe_pkg::*; (
    input  logic              CLK,
    input  logic              RESET_N,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic [4:0]        rd,
    input  logic [DATA_W-1:0] wdata,
    input  logic              we,
    output logic [DATA_W-1:0] rdata1,
    output logic [DATA_W-1:0] rdata2
);

    // x1 to x31, x0 has no storage
    logic [DATA_W-1:0] regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // same cycle write goes straight through to decode
    always_comb begin
        if (rs1 == 5'd0)                rdata1 = '0;
        else if (we && rd == rs1)       rdata1 = wdata;
        else                            rdata1 = regs[rs1];

        if (rs2 == 5'd0)                rdata2 = '0;
        else if (we && rd == rs2)       rdata2 = wdata;
        else                            rdata2 = regs[rs2];
    end

endmodule

// File: hdl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     RESET_N,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // bubble wins over hold so a flush also clears a stalled stage
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            q <= '0;
        end else if (bubble) begin
            // all zero payload also drops the valid bit
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: hdl/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    localparam int DATA_W = 32;
    // word address of both memories
    localparam int ADDR_W = 10;
    // byte pc
    localparam int PC_W   = ADDR_W + 2;

    // fetch to decode
    typedef struct packed {
        logic              valid;
        logic [PC_W-1:0]   pc;
        logic [DATA_W-1:0] instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              branch;
        logic              alu_src_imm;
        wb_src_e           wb_src;
        logic [PC_W-1:0]   pc;
        logic [DATA_W-1:0] op1;
        logic [DATA_W-1:0] op2;
        logic [DATA_W-1:0] imm;
        alu_op_e           alu_op;
        logic [4:0]        rd;
        logic [2:0]        funct3;
    } id_ex_t;

    // execute to memory
    // target is the full pc plus immediate sum, also the auipc value
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              branch;
        wb_src_e           wb_src;
        logic [DATA_W-1:0] alu_result;
        logic              zero;
        logic [DATA_W-1:0] store_data;
        logic [DATA_W-1:0] target;
        logic [4:0]        rd;
        logic [2:0]        funct3;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic              valid;
        logic              reg_write;
        wb_src_e           wb_src;
        logic [DATA_W-1:0] alu_result;
        logic [DATA_W-1:0] load_data;
        logic [4:0]        rd;
        logic [DATA_W-1:0] link;
    } mem_wb_t;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 of register and immediate arithmetic
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // word access only
    localparam logic [2:0] FUNCT3_LW = 3'b010;
    localparam logic [2:0] FUNCT3_SW = 3'b010;

    // conditional branches
    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // value written back to rd
    typedef enum logic [1:0] {
        WB_ALU    = 2'd0,
        WB_MEM    = 2'd1,
        WB_PC_IMM = 2'd2
    } wb_src_e;

endpackage
